//--- include/ao_periph_params.svh
/*
 * Address map, peripheral indices, GPIO width and decode-error word
 */
`ifndef AO_PERIPH_PARAMS_SVH
`define AO_PERIPH_PARAMS_SVH

// Subsystem window, bits 31..12 must match
`define AO_BASE_ADDR 32'h2000_0000

// Peripheral index in address bits 11..8
`define AO_SOC_CTRL_IDX 4'd0
`define AO_TIMER_IDX    4'd1
`define AO_GPIO_IDX     4'd2
`define AO_NUM_PERIPH   3

`define AO_GPIO_WIDTH 8

// Returned on reads outside the map
`define AO_DECODE_ERR_DATA 32'hBADC_AB1E

`endif

//--- src/ao_periph_pkg.sv
/*
 * Address word union and byte-enable merge helper
 */
package ao_periph_pkg;

  typedef struct packed {
    logic [19:0] base;
    logic [3:0]  idx;
    logic [5:0]  word_off;
    logic [1:0]  byte_off;
  } ao_addr_fields_t;

  // Same word, raw byte address or decoded fields
  typedef union packed {
    logic [31:0]     raw;
    ao_addr_fields_t f;
  } ao_addr_u;

  function automatic logic [31:0] apply_be(logic [31:0] old_word, logic [31:0] new_word,
                                           logic [3:0] be);
    logic [31:0] res;
    for (int i = 0; i < 4; i++) begin
      res[i*8+:8] = be[i] ? new_word[i*8+:8] : old_word[i*8+:8];
    end
    return res;
  endfunction

endpackage

//--- src/obi_reg_bridge.sv
/*
 * OBI slave to single-cycle register bus, one transaction in flight
 */
`timescale 1ns/1ps

module obi_reg_bridge
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        reg_valid_o,
  output logic        reg_we_o,
  output logic [31:0] reg_addr_o,
  output logic [3:0]  reg_be_o,
  output logic [31:0] reg_wdata_o,
  input  logic [31:0] reg_rdata_i
);

  logic     busy_q;
  logic     resp_q;
  logic     accept;
  ao_addr_u addr_q;

  assign accept     = req_i & ~busy_q;
  assign gnt_o      = accept;
  assign reg_addr_o = addr_q.raw;

  // Busy from grant until the response pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      reg_valid_o <= 1'b0;
      resp_q      <= 1'b0;
      rvalid_o    <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (resp_q) begin
        busy_q <= 1'b0;
      end
      reg_valid_o <= accept;
      resp_q      <= reg_valid_o;
      rvalid_o    <= resp_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      reg_we_o    <= we_i;
      addr_q.raw  <= addr_i;
      reg_be_o    <= be_i;
      reg_wdata_o <= wdata_i;
    end
    // Read data sampled during the access cycle
    if (reg_valid_o) begin
      rdata_o <= reg_rdata_i;
    end
  end

endmodule

//--- src/ao_reg_demux.sv
/*
 * Register bus address decode, per-peripheral selects and read-data mux
 */
`timescale 1ns/1ps
`include "ao_periph_params.svh"

module ao_reg_demux
  import ao_periph_pkg::*;
(
  input  logic        reg_valid_i,
  input  logic        reg_we_i,
  input  logic [31:0] reg_addr_i,
  input  logic [3:0]  reg_be_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  input  logic [31:0] soc_rdata_i,
  input  logic [31:0] tmr_rdata_i,
  input  logic [31:0] gpio_rdata_i,
  output logic        soc_sel_o,
  output logic        tmr_sel_o,
  output logic        gpio_sel_o,
  output logic        per_we_o,
  output logic [5:0]  per_offset_o,
  output logic [3:0]  per_be_o,
  output logic [31:0] per_wdata_o
);

  localparam logic [31:0] base_addr = `AO_BASE_ADDR;

  ao_addr_u addr;
  logic     mapped;

  assign addr.raw = reg_addr_i;
  assign mapped   = (addr.f.base == base_addr[31:12]) && (addr.f.idx < `AO_NUM_PERIPH);

  // Unmapped writes raise no select and are dropped
  assign soc_sel_o  = reg_valid_i && mapped && (addr.f.idx == `AO_SOC_CTRL_IDX);
  assign tmr_sel_o  = reg_valid_i && mapped && (addr.f.idx == `AO_TIMER_IDX);
  assign gpio_sel_o = reg_valid_i && mapped && (addr.f.idx == `AO_GPIO_IDX);

  assign per_we_o     = reg_we_i;
  assign per_offset_o = addr.f.word_off;
  assign per_be_o     = reg_be_i;
  assign per_wdata_o  = reg_wdata_i;

  always_comb begin
    reg_rdata_o = `AO_DECODE_ERR_DATA;
    if (mapped) begin
      case (addr.f.idx)
        `AO_SOC_CTRL_IDX: reg_rdata_o = soc_rdata_i;
        `AO_TIMER_IDX:    reg_rdata_o = tmr_rdata_i;
        `AO_GPIO_IDX:     reg_rdata_o = gpio_rdata_i;
        default:          reg_rdata_o = `AO_DECODE_ERR_DATA;
      endcase
    end
  end

endmodule

//--- src/soc_ctrl.sv
/*
 * SoC control registers: exit signalling, boot select, scratch
 */
`timescale 1ns/1ps

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        sel_i,
  input  logic        we_i,
  input  logic [5:0]  offset_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic        wr;
  logic        boot_sel_q;
  logic [31:0] scratch_q;

  assign wr = sel_i & we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      boot_sel_q   <= 1'b0;
      scratch_q    <= '0;
    end else begin
      boot_sel_q <= boot_select_i;
      if (wr) begin
        case (offset_i)
          6'd0: if (be_i[0]) exit_valid_o <= wdata_i[0];
          6'd1: exit_value_o <= apply_be(exit_value_o, wdata_i, be_i);
          6'd3: scratch_q <= apply_be(scratch_q, wdata_i, be_i);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset_i)
      6'd0:    rdata_o = {31'b0, exit_valid_o};
      6'd1:    rdata_o = exit_value_o;
      6'd2:    rdata_o = {31'b0, boot_sel_q};
      6'd3:    rdata_o = scratch_q;
      default: rdata_o = '0;
    endcase
  end

endmodule

//--- src/ao_timer.sv
/*
 * Free-running compare timer with sticky interrupt status
 */
`timescale 1ns/1ps

module ao_timer
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        sel_i,
  input  logic        we_i,
  input  logic [5:0]  offset_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        timer_intr_o
);

  logic        wr;
  logic        en_q;
  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic        status_q;
  logic        hit;
  logic        clr;

  assign wr  = sel_i & we_i;
  assign hit = en_q && (count_q == compare_q);
  // Write 1 clears, a hit in the same cycle wins
  assign clr = wr && (offset_i == 6'd3) && be_i[0] && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q      <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      status_q  <= 1'b0;
    end else begin
      if (wr && (offset_i == 6'd0) && be_i[0]) begin
        en_q <= wdata_i[0];
      end
      if (wr && (offset_i == 6'd1)) begin
        count_q <= apply_be(count_q, wdata_i, be_i);
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr && (offset_i == 6'd2)) begin
        compare_q <= apply_be(compare_q, wdata_i, be_i);
      end
      status_q <= (status_q & ~clr) | hit;
    end
  end

  assign timer_intr_o = status_q;

  always_comb begin
    case (offset_i)
      6'd0:    rdata_o = {31'b0, en_q};
      6'd1:    rdata_o = count_q;
      6'd2:    rdata_o = compare_q;
      6'd3:    rdata_o = {31'b0, status_q};
      default: rdata_o = '0;
    endcase
  end

endmodule

//--- src/gpio_ao.sv
/*
 * Always-on GPIO with synchronised inputs and rising-edge interrupts
 */
`timescale 1ns/1ps
`include "ao_periph_params.svh"

module gpio_ao (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      sel_i,
  input  logic                      we_i,
  input  logic [5:0]                offset_i,
  input  logic [3:0]                be_i,
  input  logic [31:0]               wdata_i,
  output logic [31:0]               rdata_o,
  input  logic [`AO_GPIO_WIDTH-1:0] gpio_i,
  output logic [`AO_GPIO_WIDTH-1:0] gpio_o,
  output logic [`AO_GPIO_WIDTH-1:0] gpio_en_o,
  output logic [`AO_GPIO_WIDTH-1:0] intr_gpio_o
);

  localparam int w = `AO_GPIO_WIDTH;

  logic         wr;
  logic [w-1:0] sync1_q;
  logic [w-1:0] sync2_q;
  logic [w-1:0] prev_q;
  logic [w-1:0] intr_en_q;
  logic [w-1:0] rise;
  logic [w-1:0] clr;

  assign wr   = sel_i & we_i & be_i[0];
  assign rise = sync2_q & ~prev_q & intr_en_q;
  assign clr  = (wr && (offset_i == 6'd4)) ? wdata_i[w-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q     <= '0;
      sync2_q     <= '0;
      prev_q      <= '0;
      gpio_o      <= '0;
      gpio_en_o   <= '0;
      intr_en_q   <= '0;
      intr_gpio_o <= '0;
    end else begin
      // Two-flop synchroniser, then edge detect
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && (offset_i == 6'd1)) gpio_o <= wdata_i[w-1:0];
      if (wr && (offset_i == 6'd2)) gpio_en_o <= wdata_i[w-1:0];
      if (wr && (offset_i == 6'd3)) intr_en_q <= wdata_i[w-1:0];
      intr_gpio_o <= (intr_gpio_o & ~clr) | rise;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      6'd0:    rdata_o[w-1:0] = sync2_q;
      6'd1:    rdata_o[w-1:0] = gpio_o;
      6'd2:    rdata_o[w-1:0] = gpio_en_o;
      6'd3:    rdata_o[w-1:0] = intr_en_q;
      6'd4:    rdata_o[w-1:0] = intr_gpio_o;
      default: rdata_o = '0;
    endcase
  end

endmodule

//--- src/ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem: OBI bridge, register demux,
 * SoC control, compare timer and GPIO
 */
`timescale 1ns/1ps
`include "ao_periph_params.svh"

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [31:0]               addr_i,
  input  logic [3:0]                be_i,
  input  logic [31:0]               wdata_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic [31:0]               rdata_o,
  input  logic                      boot_select_i,
  output logic                      exit_valid_o,
  output logic [31:0]               exit_value_o,
  output logic                      timer_intr_o,
  input  logic [`AO_GPIO_WIDTH-1:0] gpio_i,
  output logic [`AO_GPIO_WIDTH-1:0] gpio_o,
  output logic [`AO_GPIO_WIDTH-1:0] gpio_en_o,
  output logic [`AO_GPIO_WIDTH-1:0] intr_gpio_o
);

  logic        reg_valid;
  logic        reg_we;
  ao_addr_u    reg_addr;
  logic [3:0]  reg_be;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;

  logic        soc_sel;
  logic        tmr_sel;
  logic        gpio_sel;
  logic        per_we;
  logic [5:0]  per_offset;
  logic [3:0]  per_be;
  logic [31:0] per_wdata;
  logic [31:0] soc_rdata;
  logic [31:0] tmr_rdata;
  logic [31:0] gpio_rdata;

  obi_reg_bridge u_bridge (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .be_i       (be_i),
    .wdata_i    (wdata_i),
    .gnt_o      (gnt_o),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o),
    .reg_valid_o(reg_valid),
    .reg_we_o   (reg_we),
    .reg_addr_o (reg_addr.raw),
    .reg_be_o   (reg_be),
    .reg_wdata_o(reg_wdata),
    .reg_rdata_i(reg_rdata)
  );

  ao_reg_demux u_demux (
    .reg_valid_i (reg_valid),
    .reg_we_i    (reg_we),
    .reg_addr_i  (reg_addr.raw),
    .reg_be_i    (reg_be),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .soc_rdata_i (soc_rdata),
    .tmr_rdata_i (tmr_rdata),
    .gpio_rdata_i(gpio_rdata),
    .soc_sel_o   (soc_sel),
    .tmr_sel_o   (tmr_sel),
    .gpio_sel_o  (gpio_sel),
    .per_we_o    (per_we),
    .per_offset_o(per_offset),
    .per_be_o    (per_be),
    .per_wdata_o (per_wdata)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .sel_i        (soc_sel),
    .we_i         (per_we),
    .offset_i     (per_offset),
    .be_i         (per_be),
    .wdata_i      (per_wdata),
    .rdata_o      (soc_rdata),
    .boot_select_i(boot_select_i),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o)
  );

  ao_timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sel_i       (tmr_sel),
    .we_i        (per_we),
    .offset_i    (per_offset),
    .be_i        (per_be),
    .wdata_i     (per_wdata),
    .rdata_o     (tmr_rdata),
    .timer_intr_o(timer_intr_o)
  );

  gpio_ao u_gpio (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sel_i      (gpio_sel),
    .we_i       (per_we),
    .offset_i   (per_offset),
    .be_i       (per_be),
    .wdata_i    (per_wdata),
    .rdata_o    (gpio_rdata),
    .gpio_i     (gpio_i),
    .gpio_o     (gpio_o),
    .gpio_en_o  (gpio_en_o),
    .intr_gpio_o(intr_gpio_o)
  );

endmodule

//--- bench/tb_ao_peripheral_subsystem.sv
/*
 * Directed testbench for the always-on peripheral subsystem
 */
`timescale 1ns/1ps
`include "ao_periph_params.svh"

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  // Roughly 650 cycles of bus traffic and waits plus a wide margin
  localparam int cycle_limit = 4000;

  logic       clk;
  logic       rst_n;
  logic       req;
  logic       we;
  logic [31:0] addr;
  logic [3:0] be;
  logic [31:0] wdata;
  logic       gnt;
  logic       rvalid;
  logic [31:0] rdata;
  logic       boot_select;
  logic       exit_valid;
  logic [31:0] exit_value;
  logic       timer_intr;
  logic [7:0] gpio_in;
  logic [7:0] gpio_out;
  logic [7:0] gpio_en;
  logic [7:0] intr_gpio;

  int          mismatch_count;
  int          other_count;
  int          cycle_count = 0;
  logic [31:0] lfsr_state;
  logic [31:0] scratch_exp;
  logic [31:0] exit_value_exp;
  logic [7:0]  gpio_out_exp;
  logic [7:0]  gpio_oe_exp;

  ao_peripheral_subsystem u_ao_peripheral_subsystem (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .be_i         (be),
    .wdata_i      (wdata),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .boot_select_i(boot_select),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value),
    .timer_intr_o (timer_intr),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en),
    .intr_gpio_o  (intr_gpio)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("ERROR: run stopped after %0d cycles without finishing", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] lfsr_take(int nbits);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic logic [31:0] reg_addr(logic [3:0] idx, logic [5:0] offset);
    logic [31:0] base;
    ao_addr_u    a;
    base = `AO_BASE_ADDR;
    a.f.base     = base[31:12];
    a.f.idx      = idx;
    a.f.word_off = offset;
    a.f.byte_off = 2'b00;
    return a.raw;
  endfunction

  function automatic logic [31:0] byte_mask(logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic report_error(string what);
    $display("ERROR: %s", what);
    other_count++;
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Starts 1 ns after a rising edge and returns at the same point
  task automatic bus_access(input logic we_op, input logic [31:0] a, input logic [3:0] sel,
                            input logic [31:0] data, output logic [31:0] resp);
    int waited;
    int lat;
    req   = 1'b1;
    we    = we_op;
    addr  = a;
    be    = sel;
    wdata = data;
    resp  = '0;
    waited = 0;
    @(negedge clk);
    while (!gnt && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!gnt) begin
      report_error($sformatf("no grant for access to 0x%08h", a));
      @(posedge clk);
      #1;
      req = 1'b0;
    end else begin
      // Grant edge
      @(posedge clk);
      #1;
      req = 1'b0;
      we  = 1'b0;
      lat = 0;
      @(negedge clk);
      while (!rvalid && lat < 6) begin
        @(negedge clk);
        lat++;
      end
      if (!rvalid) begin
        report_error($sformatf("no response for access to 0x%08h", a));
      end else if (lat != 2) begin
        report_error($sformatf("response %0d cycles after grant instead of 2", lat));
      end
      resp = rdata;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [3:0] sel, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, a, sel, data, unused);
  endtask

  task automatic bus_read(input logic [31:0] a, output logic [31:0] data);
    bus_access(1'b0, a, 4'hf, 32'h0, data);
  endtask

  task automatic check_reset_state();
    logic [31:0] d;
    check_value("exit_valid_o", {31'b0, exit_valid}, 32'h0);
    check_value("exit_value_o", exit_value, 32'h0);
    check_value("timer_intr_o", {31'b0, timer_intr}, 32'h0);
    check_value("gpio_o", {24'b0, gpio_out}, 32'h0);
    check_value("gpio_en_o", {24'b0, gpio_en}, 32'h0);
    check_value("intr_gpio_o", {24'b0, intr_gpio}, 32'h0);
    check_value("rvalid_o", {31'b0, rvalid}, 32'h0);
    check_value("gnt_o", {31'b0, gnt}, 32'h0);
    for (int off = 0; off < 4; off++) begin
      bus_read(reg_addr(`AO_SOC_CTRL_IDX, off[5:0]), d);
      check_value("rdata_o (soc_ctrl)", d, (off == 2) ? {31'b0, boot_select} : 32'h0);
      bus_read(reg_addr(`AO_TIMER_IDX, off[5:0]), d);
      check_value("rdata_o (timer)", d, 32'h0);
    end
    for (int off = 0; off < 5; off++) begin
      bus_read(reg_addr(`AO_GPIO_IDX, off[5:0]), d);
      check_value("rdata_o (gpio)", d, 32'h0);
    end
    // BOOT_SELECT follows the other pin level too
    boot_select = 1'b0;
    wait_cycles(2);
    bus_read(reg_addr(`AO_SOC_CTRL_IDX, 6'd2), d);
    check_value("rdata_o (BOOT_SELECT)", d, 32'h0);
  endtask

  task automatic soc_ctrl_accesses();
    logic [31:0] w;
    logic [31:0] mask;
    logic [31:0] d;
    logic [3:0]  sel;
    for (int i = 0; i < 8; i++) begin
      w    = lfsr_take(32);
      mask = lfsr_take(4);
      // Full words first and random byte enables after
      sel  = (i < 4) ? 4'hf : mask[3:0];
      bus_write(reg_addr(`AO_SOC_CTRL_IDX, 6'd3), sel, w);
      mask = byte_mask(sel);
      scratch_exp = (scratch_exp & ~mask) | (w & mask);
      bus_read(reg_addr(`AO_SOC_CTRL_IDX, 6'd3), d);
      check_value("rdata_o (SCRATCH)", d, scratch_exp);
    end
    exit_value_exp = lfsr_take(32);
    bus_write(reg_addr(`AO_SOC_CTRL_IDX, 6'd1), 4'hf, exit_value_exp);
    check_value("exit_value_o", exit_value, exit_value_exp);
    check_value("exit_valid_o", {31'b0, exit_valid}, 32'h0);
    bus_write(reg_addr(`AO_SOC_CTRL_IDX, 6'd0), 4'h1, 32'h1);
    check_value("exit_valid_o", {31'b0, exit_valid}, 32'h1);
    bus_read(reg_addr(`AO_SOC_CTRL_IDX, 6'd1), d);
    check_value("rdata_o (EXIT_VALUE)", d, exit_value_exp);
  endtask

  task automatic gpio_io_loopback();
    logic [31:0] r;
    logic [31:0] d;
    r = lfsr_take(8);
    gpio_out_exp = r[7:0];
    bus_write(reg_addr(`AO_GPIO_IDX, 6'd1), 4'h1, {24'b0, gpio_out_exp});
    r = lfsr_take(8);
    gpio_oe_exp = r[7:0];
    bus_write(reg_addr(`AO_GPIO_IDX, 6'd2), 4'h1, {24'b0, gpio_oe_exp});
    check_value("gpio_o", {24'b0, gpio_out}, {24'b0, gpio_out_exp});
    check_value("gpio_en_o", {24'b0, gpio_en}, {24'b0, gpio_oe_exp});
    r = lfsr_take(8);
    gpio_in = r[7:0];
    wait_cycles(4);
    bus_read(reg_addr(`AO_GPIO_IDX, 6'd0), d);
    check_value("rdata_o (IN)", d, {24'b0, r[7:0]});
    gpio_in = '0;
    wait_cycles(4);
  endtask

  task automatic gpio_edge_interrupts();
    logic [31:0] r;
    logic [31:0] d;
    logic [7:0]  en;
    r  = lfsr_take(8);
    // Keep at least one pin enabled and one disabled
    en = (r[7:0] | 8'h11) & 8'h77;
    bus_write(reg_addr(`AO_GPIO_IDX, 6'd3), 4'h1, {24'b0, en});
    gpio_in = 8'hff;
    wait_cycles(4);
    check_value("intr_gpio_o", {24'b0, intr_gpio}, {24'b0, en});
    bus_read(reg_addr(`AO_GPIO_IDX, 6'd4), d);
    check_value("rdata_o (INTR_STATUS)", d, {24'b0, en});
    bus_write(reg_addr(`AO_GPIO_IDX, 6'd4), 4'h1, 32'h0000_000f);
    check_value("intr_gpio_o", {24'b0, intr_gpio}, {24'b0, en & 8'hf0});
    bus_write(reg_addr(`AO_GPIO_IDX, 6'd4), 4'h1, 32'h0000_00ff);
    check_value("intr_gpio_o", {24'b0, intr_gpio}, 32'h0);
    bus_write(reg_addr(`AO_GPIO_IDX, 6'd3), 4'h1, 32'h0);
    gpio_in = '0;
    wait_cycles(4);
  endtask

  task automatic timer_compare();
    logic [31:0] c0;
    logic [31:0] c1;
    logic [31:0] d;
    logic [31:0] count_exp;
    int          waited;
    bus_write(reg_addr(`AO_TIMER_IDX, 6'd1), 4'hf, 32'h0);
    bus_write(reg_addr(`AO_TIMER_IDX, 6'd2), 4'hf, 32'd50);
    bus_write(reg_addr(`AO_TIMER_IDX, 6'd0), 4'h1, 32'h1);
    waited = 0;
    while (!timer_intr && waited < 60) begin
      @(negedge clk);
      waited++;
    end
    if (!timer_intr) begin
      report_error("timer interrupt did not rise within 60 cycles");
    end
    @(posedge clk);
    #1;
    bus_read(reg_addr(`AO_TIMER_IDX, 6'd1), c0);
    bus_read(reg_addr(`AO_TIMER_IDX, 6'd1), c1);
    if (c1 <= c0) begin
      report_error($sformatf("COUNT did not grow between reads, 0x%08h then 0x%08h", c0, c1));
    end
    check_value("timer_intr_o", {31'b0, timer_intr}, 32'h1);
    bus_read(reg_addr(`AO_TIMER_IDX, 6'd3), d);
    check_value("rdata_o (STATUS)", d, 32'h1);
    bus_write(reg_addr(`AO_TIMER_IDX, 6'd0), 4'h1, 32'h0);
    bus_write(reg_addr(`AO_TIMER_IDX, 6'd3), 4'h1, 32'h1);
    check_value("timer_intr_o", {31'b0, timer_intr}, 32'h0);
    // A disabled counter holds a written value
    count_exp = lfsr_take(32);
    bus_write(reg_addr(`AO_TIMER_IDX, 6'd1), 4'hf, count_exp);
    wait_cycles(8);
    bus_read(reg_addr(`AO_TIMER_IDX, 6'd1), d);
    check_value("rdata_o (COUNT stopped)", d, count_exp);
  endtask

  task automatic decode_errors();
    logic [31:0] a;
    logic [31:0] d;
    // Wrong base with the offsets of SCRATCH and GPIO OUT
    a = reg_addr(`AO_SOC_CTRL_IDX, 6'd3) ^ 32'h1000_0000;
    bus_read(a, d);
    check_value("rdata_o (bad base)", d, `AO_DECODE_ERR_DATA);
    bus_write(a, 4'hf, ~scratch_exp);
    a = reg_addr(`AO_GPIO_IDX, 6'd1) + 32'h0000_1000;
    bus_read(a, d);
    check_value("rdata_o (bad base)", d, `AO_DECODE_ERR_DATA);
    bus_write(a, 4'hf, {24'b0, ~gpio_out_exp});
    for (int idx = 3; idx < 16; idx++) begin
      bus_read(reg_addr(idx[3:0], 6'd1), d);
      check_value("rdata_o (bad index)", d, `AO_DECODE_ERR_DATA);
      // Bit 0 low so a stray EXIT_VALID write would clear it
      for (int off = 0; off < 4; off++) begin
        bus_write(reg_addr(idx[3:0], off[5:0]), 4'hf, lfsr_take(32) & 32'hffff_fffe);
      end
    end
    bus_read(reg_addr(`AO_SOC_CTRL_IDX, 6'd3), d);
    check_value("rdata_o (SCRATCH)", d, scratch_exp);
    bus_read(reg_addr(`AO_SOC_CTRL_IDX, 6'd1), d);
    check_value("rdata_o (EXIT_VALUE)", d, exit_value_exp);
    bus_read(reg_addr(`AO_TIMER_IDX, 6'd2), d);
    check_value("rdata_o (COMPARE)", d, 32'd50);
    bus_read(reg_addr(`AO_GPIO_IDX, 6'd1), d);
    check_value("rdata_o (OUT)", d, {24'b0, gpio_out_exp});
    bus_read(reg_addr(`AO_GPIO_IDX, 6'd2), d);
    check_value("rdata_o (OE)", d, {24'b0, gpio_oe_exp});
    check_value("exit_valid_o", {31'b0, exit_valid}, 32'h1);
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    req            = 1'b0;
    we             = 1'b0;
    addr           = '0;
    be             = '0;
    wdata          = '0;
    boot_select    = 1'b1;
    gpio_in        = '0;
    mismatch_count = 0;
    other_count    = 0;
    lfsr_state     = 32'hc9fd_73c2;
    scratch_exp    = '0;
    exit_value_exp = '0;
    gpio_out_exp   = '0;
    gpio_oe_exp    = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_cycles(2);
    check_reset_state();
    soc_ctrl_accesses();
    gpio_io_loopback();
    gpio_edge_interrupts();
    timer_compare();
    decode_errors();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
src/ao_periph_pkg.sv
src/obi_reg_bridge.sv
src/ao_reg_demux.sv
src/soc_ctrl.sv
src/ao_timer.sv
src/gpio_ao.sv
src/ao_peripheral_subsystem.sv
bench/tb_ao_peripheral_subsystem.sv

//--- Makefile
TOP = tb_ao_peripheral_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timescale 1ns/1ps -f sources.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
